// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

	localparam int unsigned ADDR_W = 32;
	localparam int unsigned DATA_W = 32;

	// at most this many granted requests wait for their rvalid
	localparam int unsigned NUM_REQS = 2;

	// one spare entry so in-flight responses always land while the decoder stalls
	localparam int unsigned FIFO_DEPTH = NUM_REQS + 1;

	localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

	// wide enough for a free count from zero up to FIFO_DEPTH
	localparam int unsigned FREE_W = $clog2(FIFO_DEPTH + 1);

	typedef struct packed {
		logic              req;
		logic [ADDR_W-1:0] addr;
	} instr_bus_req_t;

	typedef struct packed {
		logic              gnt;
		logic              rvalid;
		logic [DATA_W-1:0] rdata;
		logic              err;
	} instr_bus_rsp_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic [ADDR_W-1:0] addr;
		logic              err;
	} fetch_entry_t;

	typedef enum logic {
		REQ_IDLE,
		REQ_HOLD
	} req_state_e;

endpackage

// ==== hw/fetch_req_ctrl.sv ====
`timescale 1ns/1ps

module fetch_req_ctrl (
	input  logic                         clk_i,
	input  logic                         rst_ni,
	input  logic                         req_i,
	input  logic                         branch_i,
	input  logic [fetch_pkg::ADDR_W-1:0] branch_addr_i,
	input  logic [fetch_pkg::FREE_W-1:0] fifo_free_i,
	output fetch_pkg::instr_bus_req_t    bus_req_o,
	input  fetch_pkg::instr_bus_rsp_t    bus_rsp_i,
	output logic                         resp_valid_o,
	output logic                         busy_o
);

	fetch_pkg::req_state_e state_q;
	fetch_pkg::req_state_e state_d;

	logic [fetch_pkg::ADDR_W-1:0] stored_addr_q;
	logic                         hold_discard_q;
	logic                         hold_discard_d;

	logic [fetch_pkg::ADDR_W-1:0] fetch_addr_q;
	logic [fetch_pkg::ADDR_W-1:0] fetch_addr_d;
	logic [fetch_pkg::ADDR_W-1:0] branch_addr_aligned;
	logic [fetch_pkg::ADDR_W-1:0] req_addr;

	logic [fetch_pkg::NUM_REQS-1:0] outst_q;
	logic [fetch_pkg::NUM_REQS-1:0] outst_n;
	logic [fetch_pkg::NUM_REQS-1:0] outst_d;
	logic [fetch_pkg::NUM_REQS-1:0] discard_q;
	logic [fetch_pkg::NUM_REQS-1:0] discard_n;
	logic [fetch_pkg::NUM_REQS-1:0] discard_d;
	logic [fetch_pkg::FREE_W-1:0]   outst_cnt;

	logic holding;
	logic new_req;
	logic req_valid;
	logic granted;
	logic grant_discard;
	logic rsp_in;

	assign branch_addr_aligned = {branch_addr_i[fetch_pkg::ADDR_W-1:2], 2'b00};

	always_comb begin
		outst_cnt = '0;
		for (int k = 0; k < fetch_pkg::NUM_REQS; k++) begin
			outst_cnt = outst_cnt + fetch_pkg::FREE_W'(outst_q[k]);
		end
	end

	assign holding = (state_q == fetch_pkg::REQ_HOLD);

	// a fresh request needs a free FIFO slot for every response that could still arrive
	// the branch clears the FIFO in this same cycle so its space check is skipped
	assign new_req = req_i & ~holding & ~outst_q[fetch_pkg::NUM_REQS-1] &
		(branch_i | (fifo_free_i > outst_cnt));

	assign req_valid = holding | new_req;

	// a held address stays frozen until granted, even across a branch
	assign req_addr = holding ? stored_addr_q :
		(branch_i ? branch_addr_aligned : fetch_addr_q);

	assign granted = req_valid & bus_rsp_i.gnt;

	// the held request belongs to the old stream once a branch has been seen
	assign grant_discard = holding & (hold_discard_q | branch_i);

	assign rsp_in = outst_q[0] & bus_rsp_i.rvalid;

	assign state_d = (req_valid & ~bus_rsp_i.gnt) ? fetch_pkg::REQ_HOLD : fetch_pkg::REQ_IDLE;
	assign hold_discard_d = grant_discard & ~bus_rsp_i.gnt;

	always_comb begin
		fetch_addr_d = branch_i ? branch_addr_aligned : fetch_addr_q;
		if (new_req) begin
			fetch_addr_d = fetch_addr_d + fetch_pkg::ADDR_W'(4);
		end
	end

	always_ff @(posedge clk_i) begin
		if (new_req & ~bus_rsp_i.gnt) begin
			stored_addr_q <= req_addr;
		end
	end

	// slot 0 is always the oldest outstanding request and the one rvalid answers
	for (genvar i = 0; i < fetch_pkg::NUM_REQS; i++) begin : g_outst
		if (i == 0) begin : g_first
			assign outst_n[i] = granted | outst_q[i];
			assign discard_n[i] = (granted & grant_discard) | (branch_i & outst_q[i]) |
				discard_q[i];
		end else begin : g_rest
			assign outst_n[i] = (granted & outst_q[i-1]) | outst_q[i];
			assign discard_n[i] = (granted & grant_discard & outst_q[i-1]) |
				(branch_i & outst_q[i]) | discard_q[i];
		end
	end

	assign outst_d = rsp_in ? (outst_n >> 1) : outst_n;
	assign discard_d = rsp_in ? (discard_n >> 1) : discard_n;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q        <= fetch_pkg::REQ_IDLE;
			hold_discard_q <= 1'b0;
			fetch_addr_q   <= '0;
			outst_q        <= '0;
			discard_q      <= '0;
		end else begin
			state_q        <= state_d;
			hold_discard_q <= hold_discard_d;
			fetch_addr_q   <= fetch_addr_d;
			outst_q        <= outst_d;
			discard_q      <= discard_d;
		end
	end

	// a response arriving in the branch cycle still belongs to the old stream
	assign resp_valid_o = rsp_in & ~discard_q[0] & ~branch_i;

	assign bus_req_o.req  = req_valid;
	assign bus_req_o.addr = req_addr;

	assign busy_o = (|outst_q) | req_valid;

endmodule

// ==== hw/fetch_fifo.sv ====
`timescale 1ns/1ps

module fetch_fifo (
	input  logic                         clk_i,
	input  logic                         rst_ni,
	input  logic                         clear_i,
	input  logic [fetch_pkg::ADDR_W-1:0] clear_addr_i,
	input  logic                         in_valid_i,
	input  logic [fetch_pkg::DATA_W-1:0] in_rdata_i,
	input  logic                         in_err_i,
	output logic [fetch_pkg::FREE_W-1:0] free_o,
	output logic                         out_valid_o,
	output fetch_pkg::fetch_entry_t      out_entry_o,
	input  logic                         out_ready_i
);

	logic [fetch_pkg::DATA_W-1:0] rdata_mem [fetch_pkg::FIFO_DEPTH];
	logic [fetch_pkg::FIFO_DEPTH-1:0] err_mem;

	logic [fetch_pkg::PTR_W-1:0]  wr_ptr_q;
	logic [fetch_pkg::PTR_W-1:0]  rd_ptr_q;
	logic [fetch_pkg::FREE_W-1:0] count_q;
	logic [fetch_pkg::ADDR_W-1:0] head_addr_q;

	logic push;
	logic pop;

	function automatic logic [fetch_pkg::PTR_W-1:0] ptr_inc(
		input logic [fetch_pkg::PTR_W-1:0] ptr
	);
		if (ptr == fetch_pkg::PTR_W'(fetch_pkg::FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// the request controller never issues beyond free space so a push always fits
	assign push = in_valid_i & ~clear_i;
	assign pop  = out_valid_o & out_ready_i & ~clear_i;

	always_ff @(posedge clk_i) begin
		if (push) begin
			rdata_mem[wr_ptr_q] <= in_rdata_i;
			err_mem[wr_ptr_q]   <= in_err_i;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else if (clear_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= ptr_inc(wr_ptr_q);
			end
			if (pop) begin
				rd_ptr_q <= ptr_inc(rd_ptr_q);
			end
			case ({push, pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// words come back in order, so the head address is enough to tag every entry
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			head_addr_q <= '0;
		end else if (clear_i) begin
			head_addr_q <= {clear_addr_i[fetch_pkg::ADDR_W-1:2], 2'b00};
		end else if (pop) begin
			head_addr_q <= head_addr_q + fetch_pkg::ADDR_W'(4);
		end
	end

	assign out_valid_o = (count_q != '0);

	assign out_entry_o.rdata = rdata_mem[rd_ptr_q];
	assign out_entry_o.addr  = head_addr_q;
	assign out_entry_o.err   = err_mem[rd_ptr_q];

	assign free_o = fetch_pkg::FREE_W'(fetch_pkg::FIFO_DEPTH) - count_q;

endmodule

// ==== hw/fetch_out_stage.sv ====
`timescale 1ns/1ps

module fetch_out_stage (
	input  logic                    clk_i,
	input  logic                    rst_ni,
	input  logic                    flush_i,
	input  logic                    in_valid_i,
	input  fetch_pkg::fetch_entry_t in_entry_i,
	output logic                    in_ready_o,
	output logic                    valid_o,
	output fetch_pkg::fetch_entry_t entry_o,
	input  logic                    ready_i
);

	logic                    valid_q;
	fetch_pkg::fetch_entry_t entry_q;
	logic                    load;

	// the slot takes a new word when empty or when the decoder drains it this cycle
	assign in_ready_o = ~valid_q | ready_i;
	assign load       = in_valid_i & in_ready_o & ~flush_i;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			valid_q <= 1'b0;
		end else if (flush_i) begin
			valid_q <= 1'b0;
		end else if (in_ready_o) begin
			valid_q <= in_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (load) begin
			entry_q <= in_entry_i;
		end
	end

	assign valid_o = valid_q;
	assign entry_o = entry_q;

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
	input  logic                         clk_i,
	input  logic                         rst_ni,
	input  logic                         req_i,
	input  logic                         branch_i,
	input  logic [fetch_pkg::ADDR_W-1:0] branch_addr_i,
	input  logic                         ready_i,
	output logic                         valid_o,
	output logic [fetch_pkg::DATA_W-1:0] rdata_o,
	output logic [fetch_pkg::ADDR_W-1:0] addr_o,
	output logic                         err_o,
	output logic                         busy_o,
	output logic                         instr_req_o,
	output logic [fetch_pkg::ADDR_W-1:0] instr_addr_o,
	input  logic                         instr_gnt_i,
	input  logic                         instr_rvalid_i,
	input  logic [fetch_pkg::DATA_W-1:0] instr_rdata_i,
	input  logic                         instr_err_i
);

	fetch_pkg::instr_bus_req_t    bus_req;
	fetch_pkg::instr_bus_rsp_t    bus_rsp;
	logic [fetch_pkg::FREE_W-1:0] fifo_free;
	logic                         resp_valid;
	logic                         fifo_valid;
	logic                         fifo_ready;
	fetch_pkg::fetch_entry_t      fifo_entry;
	fetch_pkg::fetch_entry_t      out_entry;

	assign bus_rsp.gnt    = instr_gnt_i;
	assign bus_rsp.rvalid = instr_rvalid_i;
	assign bus_rsp.rdata  = instr_rdata_i;
	assign bus_rsp.err    = instr_err_i;

	assign instr_req_o  = bus_req.req;
	assign instr_addr_o = bus_req.addr;

	fetch_req_ctrl i_req_ctrl (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.req_i         (req_i),
		.branch_i      (branch_i),
		.branch_addr_i (branch_addr_i),
		.fifo_free_i   (fifo_free),
		.bus_req_o     (bus_req),
		.bus_rsp_i     (bus_rsp),
		.resp_valid_o  (resp_valid),
		.busy_o        (busy_o)
	);

	fetch_fifo i_fifo (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.clear_i      (branch_i),
		.clear_addr_i (branch_addr_i),
		.in_valid_i   (resp_valid),
		.in_rdata_i   (bus_rsp.rdata),
		.in_err_i     (bus_rsp.err),
		.free_o       (fifo_free),
		.out_valid_o  (fifo_valid),
		.out_entry_o  (fifo_entry),
		.out_ready_i  (fifo_ready)
	);

	fetch_out_stage i_out (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.flush_i    (branch_i),
		.in_valid_i (fifo_valid),
		.in_entry_i (fifo_entry),
		.in_ready_o (fifo_ready),
		.valid_o    (valid_o),
		.entry_o    (out_entry),
		.ready_i    (ready_i)
	);

	assign rdata_o = out_entry.rdata;
	assign addr_o  = out_entry.addr;
	assign err_o   = out_entry.err;

endmodule

// ==== verification/instr_bus_model.sv ====
`timescale 1ns/1ps

module instr_bus_model #(
	parameter int SEED = 1
) (
	input  logic                         clk_i,
	input  logic                         rst_ni,
	input  logic                         req_i,
	input  logic [fetch_pkg::ADDR_W-1:0] addr_i,
	output logic                         gnt_o,
	output logic                         rvalid_o,
	output logic [fetch_pkg::ADDR_W-1:0] rsp_addr_o
);

	int                           seed = SEED;
	int unsigned                  cycle = 0;
	int unsigned                  last_due = 0;
	logic [1:0]                   gnt_wait_q = 2'd0;
	logic                         rvalid_q = 1'b0;
	logic [fetch_pkg::ADDR_W-1:0] rsp_addr_q = '0;
	logic [fetch_pkg::ADDR_W-1:0] addr_fifo [$];
	int unsigned                  due_fifo [$];

	// a request is granted once its random wait has run down to zero
	assign gnt_o      = req_i & (gnt_wait_q == 2'd0);
	assign rvalid_o   = rvalid_q;
	assign rsp_addr_o = rsp_addr_q;

	always @(posedge clk_i or negedge rst_ni) begin
		int unsigned due;
		if (!rst_ni) begin
			cycle    = 0;
			last_due = 0;
			addr_fifo.delete();
			due_fifo.delete();
			gnt_wait_q <= 2'd0;
		end else begin
			cycle++;
			if (rvalid_q) begin
				void'(addr_fifo.pop_front());
				void'(due_fifo.pop_front());
			end
			if (req_i) begin
				if (gnt_wait_q == 2'd0) begin
					// answers stay in grant order and never share a cycle
					due = cycle + ($unsigned($random(seed)) % 4);
					if (due <= last_due) begin
						due = last_due + 1;
					end
					last_due = due;
					addr_fifo.push_back(addr_i);
					due_fifo.push_back(due);
					gnt_wait_q <= 2'($unsigned($random(seed)) % 4);
				end else begin
					gnt_wait_q <= gnt_wait_q - 2'd1;
				end
			end
		end
	end

	always @(negedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rvalid_q <= 1'b0;
		end else if (due_fifo.size() != 0 && due_fifo[0] <= cycle) begin
			rvalid_q   <= 1'b1;
			rsp_addr_q <= addr_fifo[0];
		end else begin
			rvalid_q <= 1'b0;
		end
	end

endmodule

// ==== verification/fetch_unit_props.sv ====
`timescale 1ns/1ps

module fetch_unit_props (
	input logic                         clk_i,
	input logic                         rst_ni,
	input logic                         branch_i,
	input logic                         ready_i,
	input logic                         valid_i,
	input logic [fetch_pkg::DATA_W-1:0] rdata_i,
	input logic [fetch_pkg::ADDR_W-1:0] addr_i,
	input logic                         err_i,
	input logic                         instr_req_i,
	input logic [fetch_pkg::ADDR_W-1:0] instr_addr_i,
	input logic                         instr_gnt_i,
	input logic                         instr_rvalid_i
);

	int unsigned fail_count = 0;
	logic [2:0]  outst_q;

	// granted requests still waiting for their rvalid
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			outst_q <= '0;
		end else begin
			outst_q <= outst_q + 3'(instr_req_i & instr_gnt_i) - 3'(instr_rvalid_i);
		end
	end

	addr_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
		instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
	else begin
		fail_count++;
		$error("request dropped or address changed before the grant");
	end

	outst_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
		outst_q <= 3'(fetch_pkg::NUM_REQS))
	else begin
		fail_count++;
		$error("more than NUM_REQS requests outstanding");
	end

	reset_quiet: assert property (@(posedge clk_i) $rose(rst_ni) |-> !instr_req_i && !valid_i)
	else begin
		fail_count++;
		$error("instr_req_o or valid_o high right after reset");
	end

	// a stalled decoder slot keeps its instruction unless a branch kills it
	out_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		valid_i && !ready_i && !branch_i |=>
		valid_i && $stable(rdata_i) && $stable(addr_i) && $stable(err_i))
	else begin
		fail_count++;
		$error("output changed while ready_i was low");
	end

endmodule

bind fetch_unit fetch_unit_props i_props (
	.clk_i          (clk_i),
	.rst_ni         (rst_ni),
	.branch_i       (branch_i),
	.ready_i        (ready_i),
	.valid_i        (valid_o),
	.rdata_i        (rdata_o),
	.addr_i         (addr_o),
	.err_i          (err_o),
	.instr_req_i    (instr_req_o),
	.instr_addr_i   (instr_addr_o),
	.instr_gnt_i    (instr_gnt_i),
	.instr_rvalid_i (instr_rvalid_i)
);

// ==== verification/fetch_unit_tb.sv ====
`timescale 1ns/1ps

module fetch_unit_tb;

	localparam int          SEED          = 78711;
	localparam int unsigned SEQ_XFERS     = 24;
	localparam int unsigned NUM_JUMPS     = 3;
	localparam int unsigned JUMP_XFERS    = 8;
	localparam int unsigned STALL_XFERS   = 40;
	localparam int unsigned PLANNED_XFERS = SEQ_XFERS + NUM_JUMPS * JUMP_XFERS + STALL_XFERS;

	logic        clk;
	logic        rst_n;
	logic        req;
	logic        branch;
	logic [31:0] branch_addr;
	logic        ready;
	logic        valid;
	logic [31:0] rdata;
	logic [31:0] addr;
	logic        err;
	logic        busy;
	logic        instr_req;
	logic [31:0] instr_addr;
	logic        instr_gnt;
	logic        instr_rvalid;
	logic [31:0] instr_rdata;
	logic        instr_err;
	logic [31:0] rsp_addr;

	int          seed;
	logic        random_ready;
	logic [31:0] exp_addr;
	int unsigned xfer_count;
	int unsigned mismatches;
	int unsigned failures;

	// memory image is the word address rotated left by seven and scrambled
	function automatic logic [31:0] mem_word(input logic [31:0] word_byte_addr);
		logic [31:0] w;
		w = word_byte_addr >> 2;
		return {w[24:0], w[31:25]} ^ 32'h5A3C_96E1;
	endfunction

	function automatic logic err_expected(input logic [31:0] word_byte_addr);
		return word_byte_addr[7:4] == 4'hF;
	endfunction

	fetch_unit i_dut (
		.clk_i          (clk),
		.rst_ni         (rst_n),
		.req_i          (req),
		.branch_i       (branch),
		.branch_addr_i  (branch_addr),
		.ready_i        (ready),
		.valid_o        (valid),
		.rdata_o        (rdata),
		.addr_o         (addr),
		.err_o          (err),
		.busy_o         (busy),
		.instr_req_o    (instr_req),
		.instr_addr_o   (instr_addr),
		.instr_gnt_i    (instr_gnt),
		.instr_rvalid_i (instr_rvalid),
		.instr_rdata_i  (instr_rdata),
		.instr_err_i    (instr_err)
	);

	instr_bus_model #(.SEED(SEED)) i_mem (
		.clk_i      (clk),
		.rst_ni     (rst_n),
		.req_i      (instr_req),
		.addr_i     (instr_addr),
		.gnt_o      (instr_gnt),
		.rvalid_o   (instr_rvalid),
		.rsp_addr_o (rsp_addr)
	);

	assign instr_rdata = mem_word(rsp_addr);
	assign instr_err   = err_expected(rsp_addr);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic wait_cycles(input int unsigned n);
		repeat (n) @(negedge clk);
	endtask

	task automatic wait_transfers(input int unsigned n);
		int unsigned target;
		target = xfer_count + n;
		while (xfer_count < target) begin
			@(negedge clk);
			if (random_ready) begin
				ready = ($random(seed) % 2) != 0;
			end
		end
	endtask

	task automatic branch_to(input logic [31:0] target);
		branch      = 1'b1;
		branch_addr = target;
		@(negedge clk);
		branch      = 1'b0;
		branch_addr = $random(seed);
	endtask

	task automatic check_idle(input int unsigned limit);
		int unsigned n;
		n = 0;
		while (busy && n < limit) begin
			@(negedge clk);
			n++;
		end
		assert (!busy) else begin
			failures++;
			$display("busy_o still high %0d cycles after req_i went low", limit);
		end
	endtask

	task automatic check_transfer();
		logic [31:0] exp_rdata;
		logic        exp_err;
		exp_rdata = mem_word(exp_addr);
		exp_err   = err_expected(exp_addr);
		assert (addr == exp_addr) else begin
			mismatches++;
			$display("MISMATCH addr_o: got %h expected %h", addr, exp_addr);
		end
		assert (rdata == exp_rdata) else begin
			mismatches++;
			$display("MISMATCH rdata_o: got %h expected %h at %h", rdata, exp_rdata, exp_addr);
		end
		assert (err == exp_err) else begin
			mismatches++;
			$display("MISMATCH err_o: got %h expected %h at %h", err, exp_err, exp_addr);
		end
		exp_addr = exp_addr + 32'd4;
		xfer_count++;
	endtask

	task automatic report_and_finish();
		int unsigned prop_fails;
		prop_fails = i_dut.i_props.fail_count;
		$display("transfers %0d, mismatches %0d, other errors %0d, assertion failures %0d",
			xfer_count, mismatches, failures, prop_fails);
		if (mismatches + failures + prop_fails == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	endtask

	// a transfer in the branch cycle still belongs to the old stream
	always @(posedge clk) begin
		if (rst_n) begin
			if (valid && ready) begin
				check_transfer();
			end
			if (branch) begin
				exp_addr = {branch_addr[31:2], 2'b00};
			end
		end
	end

	initial begin
		repeat (PLANNED_XFERS * 20) @(posedge clk);
		failures++;
		$display("watchdog expired with %0d of %0d transfers done", xfer_count, PLANNED_XFERS);
		report_and_finish();
	end

	initial begin
		seed         = SEED;
		rst_n        = 1'b0;
		req          = 1'b0;
		branch       = 1'b0;
		branch_addr  = '0;
		ready        = 1'b0;
		random_ready = 1'b0;
		exp_addr     = '0;
		xfer_count   = 0;
		mismatches   = 0;
		failures     = 0;
		wait_cycles(8);
		rst_n = 1'b1;
		wait_cycles(2);

		// the start is unaligned and the stream runs through the error window at 0x1f0
		req   = 1'b1;
		ready = 1'b1;
		branch_to(32'h0000_01C2);
		wait_transfers(SEQ_XFERS);

		for (int i = 0; i < NUM_JUMPS; i++) begin
			wait_cycles($unsigned($random(seed)) % 6);
			branch_to($random(seed) & 32'h000F_FFFF);
			wait_transfers(JUMP_XFERS);
		end

		random_ready = 1'b1;
		branch_to(32'h0001_00E0);
		wait_transfers(STALL_XFERS / 2);
		branch_to(32'h0002_3F3A);
		wait_transfers(STALL_XFERS / 2);

		random_ready = 1'b0;
		ready        = 1'b1;
		req          = 1'b0;
		check_idle(16);
		wait_cycles(8);
		report_and_finish();
	end

endmodule

// ==== fetch_unit.f ====
hw/fetch_pkg.sv
hw/fetch_req_ctrl.sv
hw/fetch_fifo.sv
hw/fetch_out_stage.sv
hw/fetch_unit.sv
verification/instr_bus_model.sv
verification/fetch_unit_props.sv
verification/fetch_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module fetch_unit_tb \
	-f fetch_unit.f -o fetch_unit_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/fetch_unit_sim +verilator+error+limit+1000 > sim.log 2>&1
grep -q "^Finished with no errors$" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL, see sim.log"; exit 1; }
